// ==== source/sms_pkg.sv ====
`default_nettype none

package sms_pkg;

	// ============================================================
	// Host SD buffer and battery RAM
	// ============================================================

	typedef logic [7:0] data_t;

	// Byte offset inside one 512-byte sector
	typedef logic [8:0] byte_addr_t;

	// 16 sectors of 512 bytes make the 8 KiB save image
	localparam int SECTOR_BITS_DEFAULT = 4;

	typedef logic [SECTOR_BITS_DEFAULT+$bits(byte_addr_t)-1:0] nvram_addr_t;

	typedef logic [31:0] lba_t;

	typedef enum logic {
		BK_IDLE,
		BK_TRANSFER
	} backup_state_e;

	// ============================================================
	// Audio
	// ============================================================

	typedef logic signed [9:0]  opll_sample_t;
	typedef logic signed [15:0] psg_sample_t;
	typedef logic signed [16:0] mix_sample_t;

	// One DAC frame carries 9 melody and 9 rhythm slots
	localparam int OPLL_SLOTS_DEFAULT = 18;

endpackage

`default_nettype wire

// ==== source/host_buffer_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface host_buffer_if #(
	parameter int SECTOR_BITS = sms_pkg::SECTOR_BITS_DEFAULT
);

	// High while the host streams one sector
	logic                   ack;
	sms_pkg::byte_addr_t    buff_addr;
	// Host to RAM
	sms_pkg::data_t         buff_dout;
	logic                   buff_wr;
	// RAM to host
	sms_pkg::data_t         buff_din;
	// Sector being transferred, upper part of the RAM address
	logic [SECTOR_BITS-1:0] sector;

	modport seq (
		input  ack,
		output sector
	);

	modport ram (
		input  ack,
		input  buff_addr,
		input  buff_dout,
		input  buff_wr,
		input  sector,
		output buff_din
	);

endinterface

`default_nettype wire

// ==== source/backup_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module backup_sequencer #(
	parameter int SECTOR_BITS = sms_pkg::SECTOR_BITS_DEFAULT
) (
	input  logic              clk_sys,
	input  logic              reset_i,
	input  logic              img_mounted_i,
	input  sms_pkg::lba_t     img_size_i,
	input  logic              save_req_i,
	input  logic              download_i,
	input  logic              user_reset_i,
	input  logic              sd_ack_i,
	output sms_pkg::lba_t     sd_lba_o,
	output logic              sd_rd_o,
	output logic              sd_wr_o,
	output logic              core_reset_o,
	host_buffer_if.seq        buf_if
);

	localparam int LBA_PAD = $bits(sms_pkg::lba_t) - SECTOR_BITS;

	sms_pkg::backup_state_e state;
	logic [SECTOR_BITS-1:0] sector;

	logic mount_d;
	logic save_d;
	logic download_d;
	logic ack_d;

	logic bk_ena;
	logic start_load;
	logic start_save;
	logic dir_load;
	logic reload_done;

	logic mount_rise;
	logic save_rise;
	logic download_rise;
	logic ack_rise;
	logic ack_fall;
	logic image_valid;

	// ============================================================
	// Edge detection
	// ============================================================

	assign mount_rise    = img_mounted_i & ~mount_d;
	assign save_rise     = save_req_i & ~save_d;
	assign download_rise = download_i & ~download_d;
	assign ack_rise      = sd_ack_i & ~ack_d;
	assign ack_fall      = ~sd_ack_i & ack_d;

	// An empty image leaves backup off
	assign image_valid = (img_size_i != '0);

	// Sector index doubles as the low LBA bits
	assign sd_lba_o      = {{LBA_PAD{1'b0}}, sector};
	assign buf_if.sector = sector;

	// ============================================================
	// Sequencer
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			state        <= sms_pkg::BK_IDLE;
			sector       <= '0;
			mount_d      <= 1'b0;
			save_d       <= 1'b0;
			download_d   <= 1'b0;
			ack_d        <= 1'b0;
			bk_ena       <= 1'b0;
			start_load   <= 1'b0;
			start_save   <= 1'b0;
			dir_load     <= 1'b0;
			reload_done  <= 1'b0;
			sd_rd_o      <= 1'b0;
			sd_wr_o      <= 1'b0;
			core_reset_o <= 1'b0;
		end else begin
			mount_d    <= img_mounted_i;
			save_d     <= save_req_i;
			download_d <= download_i;
			// Previous ack level, taken from the buffer side
			ack_d      <= buf_if.ack;

			// Start requests act one cycle after the edge
			start_load <= mount_rise & image_valid;
			start_save <= save_rise;

			// A new ROM download invalidates the mounted save
			if (download_rise) begin
				bk_ena <= 1'b0;
			end
			if (mount_rise && image_valid) begin
				bk_ena <= 1'b1;
			end

			reload_done <= 1'b0;

			// Host took the request
			if (ack_rise) begin
				sd_rd_o <= 1'b0;
				sd_wr_o <= 1'b0;
			end

			case (state)
				sms_pkg::BK_IDLE: begin
					if (bk_ena && (start_load || start_save)) begin
						state    <= sms_pkg::BK_TRANSFER;
						sector   <= '0;
						dir_load <= start_load;
						sd_rd_o  <= start_load;
						sd_wr_o  <= ~start_load;
					end
				end
				sms_pkg::BK_TRANSFER: begin
					if (ack_fall) begin
						if (&sector) begin
							// Last sector done, restart the core after a load
							reload_done <= dir_load;
							state       <= sms_pkg::BK_IDLE;
						end else begin
							sector  <= sector + 1'b1;
							sd_rd_o <= dir_load;
							sd_wr_o <= ~dir_load;
						end
					end
				end
				default: begin
					state <= sms_pkg::BK_IDLE;
				end
			endcase

			core_reset_o <= user_reset_i | download_i | reload_done;
		end
	end

endmodule

`default_nettype wire

// ==== source/nvram_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module nvram_buffer #(
	parameter int SECTOR_BITS = sms_pkg::SECTOR_BITS_DEFAULT
) (
	input  logic                 clk_sys,
	input  sms_pkg::nvram_addr_t cart_addr_i,
	input  logic                 cart_we_i,
	input  sms_pkg::data_t       cart_wdata_i,
	output sms_pkg::data_t       cart_rdata_o,
	host_buffer_if.ram           buf_if
);

	localparam int ADDR_BITS = SECTOR_BITS + $bits(sms_pkg::byte_addr_t);
	localparam int DEPTH     = 2 ** ADDR_BITS;

	sms_pkg::data_t mem [DEPTH];

	logic [ADDR_BITS-1:0] cart_idx;
	logic [ADDR_BITS-1:0] host_idx;
	logic                 host_we;

	// ============================================================
	// Address decode
	// ============================================================

	assign cart_idx = cart_addr_i[ADDR_BITS-1:0];

	// Host side sees one sector at a time
	assign host_idx = {buf_if.sector, buf_if.buff_addr};

	// Strobes outside an ack window are not ours
	assign host_we = buf_if.buff_wr & buf_if.ack;

	// ============================================================
	// Dual-port array
	// ============================================================

	// Both ports read the old contents on a same-cycle write
	always_ff @(posedge clk_sys) begin
		if (cart_we_i) begin
			mem[cart_idx] <= cart_wdata_i;
		end
		if (host_we) begin
			mem[host_idx] <= buf_if.buff_dout;
		end
		cart_rdata_o    <= mem[cart_idx];
		buf_if.buff_din <= mem[host_idx];
	end

endmodule

`default_nettype wire

// ==== source/audio_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_mixer #(
	parameter int OPLL_SLOTS = sms_pkg::OPLL_SLOTS_DEFAULT
) (
	input  logic                  clk_sys,
	input  logic                  reset_i,
	input  logic                  opll_dac_clk_i,
	input  sms_pkg::opll_sample_t opll_mo_i,
	input  sms_pkg::opll_sample_t opll_ro_i,
	input  sms_pkg::psg_sample_t  psg_i,
	output sms_pkg::mix_sample_t  mix_o,
	output logic                  mix_valid_o
);

	localparam int CNT_BITS = $clog2(OPLL_SLOTS + 1);
	// Room for OPLL_SLOTS full-scale slot values
	localparam int SUM_BITS = $bits(sms_pkg::opll_sample_t) + CNT_BITS;

	typedef logic signed [SUM_BITS-1:0] sum_t;

	logic [CNT_BITS-1:0] slot_cnt;
	sum_t                mo_sum;
	sum_t                ro_sum;
	logic                dac_clk_d;
	logic                frame_end;

	logic dac_rise;
	logic dac_fall;
	logic frame_full;

	assign dac_rise   = opll_dac_clk_i & ~dac_clk_d;
	assign dac_fall   = ~opll_dac_clk_i & dac_clk_d;
	assign frame_full = (slot_cnt == CNT_BITS'(OPLL_SLOTS));

	// ============================================================
	// Slot accumulation
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			slot_cnt    <= '0;
			mo_sum      <= '0;
			ro_sum      <= '0;
			dac_clk_d   <= 1'b0;
			frame_end   <= 1'b0;
			mix_valid_o <= 1'b0;
		end else begin
			dac_clk_d   <= opll_dac_clk_i;
			frame_end   <= 1'b0;
			mix_valid_o <= frame_end;

			if (dac_rise) begin
				slot_cnt <= slot_cnt + 1'b1;
				mo_sum   <= mo_sum + sum_t'(opll_mo_i);
				ro_sum   <= ro_sum + sum_t'(opll_ro_i);
			end

			// Frame closes on the falling strobe after the last slot
			if (dac_fall && frame_full) begin
				slot_cnt  <= '0;
				mo_sum    <= '0;
				ro_sum    <= '0;
				frame_end <= 1'b1;
			end
		end
	end

	// Mixed sample, held until the next frame
	always_ff @(posedge clk_sys) begin
		if (dac_fall && frame_full) begin
			mix_o <= sms_pkg::mix_sample_t'(mo_sum) + sms_pkg::mix_sample_t'(ro_sum)
				+ sms_pkg::mix_sample_t'(psg_i);
		end
	end

endmodule

`default_nettype wire

// ==== source/sms_host_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module sms_host_bridge #(
	parameter int SECTOR_BITS = sms_pkg::SECTOR_BITS_DEFAULT,
	parameter int OPLL_SLOTS  = sms_pkg::OPLL_SLOTS_DEFAULT
) (
	input  logic                  clk_sys,
	input  logic                  reset_i,

	// Image mount and core control
	input  logic                  img_mounted_i,
	input  sms_pkg::lba_t         img_size_i,
	input  logic                  save_req_i,
	input  logic                  download_i,
	input  logic                  user_reset_i,
	output logic                  core_reset_o,

	// Host SD sector interface
	output sms_pkg::lba_t         sd_lba_o,
	output logic                  sd_rd_o,
	output logic                  sd_wr_o,
	input  logic                  sd_ack_i,
	input  sms_pkg::byte_addr_t   sd_buff_addr_i,
	input  sms_pkg::data_t        sd_buff_dout_i,
	input  logic                  sd_buff_wr_i,
	output sms_pkg::data_t        sd_buff_din_o,

	// Cartridge save RAM port
	input  sms_pkg::nvram_addr_t  cart_addr_i,
	input  logic                  cart_we_i,
	input  sms_pkg::data_t        cart_wdata_i,
	output sms_pkg::data_t        cart_rdata_o,

	// FM and PSG audio
	input  logic                  opll_dac_clk_i,
	input  sms_pkg::opll_sample_t opll_mo_i,
	input  sms_pkg::opll_sample_t opll_ro_i,
	input  sms_pkg::psg_sample_t  psg_i,
	output sms_pkg::mix_sample_t  mix_o,
	output logic                  mix_valid_o
);

	// ============================================================
	// Host buffer bundle
	// ============================================================

	host_buffer_if #(
		.SECTOR_BITS(SECTOR_BITS)
	) buf_if ();

	assign buf_if.ack       = sd_ack_i;
	assign buf_if.buff_addr = sd_buff_addr_i;
	assign buf_if.buff_dout = sd_buff_dout_i;
	assign buf_if.buff_wr   = sd_buff_wr_i;
	assign sd_buff_din_o    = buf_if.buff_din;

	// ============================================================
	// Save RAM backup
	// ============================================================

	backup_sequencer #(
		.SECTOR_BITS(SECTOR_BITS)
	) backup_sequencer_i (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.img_mounted_i(img_mounted_i),
		.img_size_i   (img_size_i),
		.save_req_i   (save_req_i),
		.download_i   (download_i),
		.user_reset_i (user_reset_i),
		.sd_ack_i     (sd_ack_i),
		.sd_lba_o     (sd_lba_o),
		.sd_rd_o      (sd_rd_o),
		.sd_wr_o      (sd_wr_o),
		.core_reset_o (core_reset_o),
		.buf_if       (buf_if.seq)
	);

	// 8 KiB battery RAM between cart and host
	nvram_buffer #(
		.SECTOR_BITS(SECTOR_BITS)
	) nvram_buffer_i (
		.clk_sys     (clk_sys),
		.cart_addr_i (cart_addr_i),
		.cart_we_i   (cart_we_i),
		.cart_wdata_i(cart_wdata_i),
		.cart_rdata_o(cart_rdata_o),
		.buf_if      (buf_if.ram)
	);

	// ============================================================
	// Audio
	// ============================================================

	audio_mixer #(
		.OPLL_SLOTS(OPLL_SLOTS)
	) audio_mixer_i (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.opll_dac_clk_i(opll_dac_clk_i),
		.opll_mo_i     (opll_mo_i),
		.opll_ro_i     (opll_ro_i),
		.psg_i         (psg_i),
		.mix_o         (mix_o),
		.mix_valid_o   (mix_valid_o)
	);

endmodule

`default_nettype wire

// ==== sim/sms_host_bridge_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module sms_host_bridge_assert (
	input logic clk_sys,
	input logic reset_i,
	input logic sd_ack_i,
	input logic sd_rd_o,
	input logic sd_wr_o,
	input logic core_reset_o,
	input logic mix_valid_o
);

	// One transfer direction at a time
	req_exclusive: assert property (@(posedge clk_sys) disable iff (reset_i)
		!(sd_rd_o && sd_wr_o))
		else $error("read and write requests are high together");

	// Requests are held until the host answers
	rd_held: assert property (@(posedge clk_sys) disable iff (reset_i)
		(sd_rd_o && !sd_ack_i) |=> sd_rd_o)
		else $error("read request dropped before ack rose");

	wr_held: assert property (@(posedge clk_sys) disable iff (reset_i)
		(sd_wr_o && !sd_ack_i) |=> sd_wr_o)
		else $error("write request dropped before ack rose");

	mix_pulse: assert property (@(posedge clk_sys) disable iff (reset_i)
		mix_valid_o |=> !mix_valid_o)
		else $error("mix_valid_o high for more than one cycle");

	reset_quiet: assert property (@(posedge clk_sys)
		reset_i |=> !(sd_rd_o || sd_wr_o || core_reset_o || mix_valid_o))
		else $error("outputs not low after reset");

endmodule

bind sms_host_bridge sms_host_bridge_assert sms_host_bridge_assert_i (
	.clk_sys     (clk_sys),
	.reset_i     (reset_i),
	.sd_ack_i    (sd_ack_i),
	.sd_rd_o     (sd_rd_o),
	.sd_wr_o     (sd_wr_o),
	.core_reset_o(core_reset_o),
	.mix_valid_o (mix_valid_o)
);

`default_nettype wire

// ==== sim/tb_sms_host_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sms_host_bridge;

	localparam string STIM_FILE = "sim/sms_stimulus.txt";

	localparam int SECTORS      = 16;
	localparam int SECTOR_BYTES = 512;
	localparam int RAM_BYTES    = SECTORS * SECTOR_BYTES;
	localparam int SLOTS        = sms_pkg::OPLL_SLOTS_DEFAULT;
	localparam int FRAMES       = 4;
	localparam int SEED_WORDS   = SECTORS;
	localparam int FRAME_WORDS  = 2 * SLOTS + 2;
	localparam int STIM_WORDS   = SEED_WORDS + FRAMES * FRAME_WORDS;

	localparam int DRIVE_DELAY     = 5;
	localparam int RESET_CYCLES    = 16;
	localparam int HOST_DELAY      = 3;
	localparam int REQ_WAIT_CYCLES = 64;

	// Transfers both ways, two cart sweeps, six audio frames, rounded up
	localparam int SECTOR_CYCLES  = 600;
	localparam int FRAME_CYCLES   = 80;
	localparam int FRAMES_RUN     = 6;
	localparam int WORK_CYCLES    = SECTORS * 2 * SECTOR_CYCLES + 2 * RAM_BYTES
		+ FRAMES_RUN * FRAME_CYCLES;
	localparam int TIMEOUT_CYCLES = (WORK_CYCLES / 10000 + 1) * 10000;

	logic                  clk_sys;
	logic                  reset_i;
	logic                  img_mounted_i;
	sms_pkg::lba_t         img_size_i;
	logic                  save_req_i;
	logic                  download_i;
	logic                  user_reset_i;
	logic                  core_reset_o;
	sms_pkg::lba_t         sd_lba_o;
	logic                  sd_rd_o;
	logic                  sd_wr_o;
	logic                  sd_ack_i;
	sms_pkg::byte_addr_t   sd_buff_addr_i;
	sms_pkg::data_t        sd_buff_dout_i;
	logic                  sd_buff_wr_i;
	sms_pkg::data_t        sd_buff_din_o;
	sms_pkg::nvram_addr_t  cart_addr_i;
	logic                  cart_we_i;
	sms_pkg::data_t        cart_wdata_i;
	sms_pkg::data_t        cart_rdata_o;
	logic                  opll_dac_clk_i;
	sms_pkg::opll_sample_t opll_mo_i;
	sms_pkg::opll_sample_t opll_ro_i;
	sms_pkg::psg_sample_t  psg_i;
	sms_pkg::mix_sample_t  mix_o;
	logic                  mix_valid_o;

	logic [31:0]    stim_mem [STIM_WORDS];
	sms_pkg::data_t save_img [RAM_BYTES];
	integer         rand_seed;
	int             err_cnt      = 0;
	int             test_cnt     = 0;
	int             bad_test_cnt = 0;
	int             valid_pulses = 0;

	sms_host_bridge sms_host_bridge_i (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.img_mounted_i (img_mounted_i),
		.img_size_i    (img_size_i),
		.save_req_i    (save_req_i),
		.download_i    (download_i),
		.user_reset_i  (user_reset_i),
		.core_reset_o  (core_reset_o),
		.sd_lba_o      (sd_lba_o),
		.sd_rd_o       (sd_rd_o),
		.sd_wr_o       (sd_wr_o),
		.sd_ack_i      (sd_ack_i),
		.sd_buff_addr_i(sd_buff_addr_i),
		.sd_buff_dout_i(sd_buff_dout_i),
		.sd_buff_wr_i  (sd_buff_wr_i),
		.sd_buff_din_o (sd_buff_din_o),
		.cart_addr_i   (cart_addr_i),
		.cart_we_i     (cart_we_i),
		.cart_wdata_i  (cart_wdata_i),
		.cart_rdata_o  (cart_rdata_o),
		.opll_dac_clk_i(opll_dac_clk_i),
		.opll_mo_i     (opll_mo_i),
		.opll_ro_i     (opll_ro_i),
		.psg_i         (psg_i),
		.mix_o         (mix_o),
		.mix_valid_o   (mix_valid_o)
	);

	// ============================================================
	// Clock, timeout and pulse counting
	// ============================================================

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		int cycle_cnt;
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("Run stopped at the limit of %0d cycles without finishing", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	// Away from the active edge, so one count per pulse
	always @(negedge clk_sys) begin
		if (mix_valid_o) begin
			valid_pulses++;
		end
	end

	// ============================================================
	// Helpers and compare tasks
	// ============================================================

	task automatic next_cycle();
		@(posedge clk_sys);
		#(DRIVE_DELAY);
	endtask

	// Pattern touches every bit of the RAM address
	function automatic sms_pkg::data_t fill_byte(input int sec, input int off);
		logic [8:0] o;
		logic [3:0] s;
		o = off[8:0];
		s = sec[3:0];
		return stim_mem[sec][7:0] ^ o[7:0] ^ {o[8], 3'b000, s};
	endfunction

	task automatic check_byte(input sms_pkg::data_t got, input sms_pkg::data_t exp,
		input string what, input int idx);
		if (got !== exp) begin
			$display("ERR %0t: %s %0d gave %h, expected %h", $time, what, idx, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_lba(input sms_pkg::lba_t got, input sms_pkg::lba_t exp, input int sec);
		if (got !== exp) begin
			$display("ERR %0t: LBA for sector %0d is %0d, expected %0d", $time, sec, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_mix(input sms_pkg::mix_sample_t got, input sms_pkg::mix_sample_t exp,
		input int frame);
		if (got !== exp) begin
			$display("ERR %0t: mix of frame %0d is %0d, expected %0d", $time, frame, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_result(input string name, input int errs_before);
		int errs;
		errs = err_cnt - errs_before;
		test_cnt++;
		if (errs == 0) begin
			$display("%s: ok", name);
		end else begin
			bad_test_cnt++;
			$display("%s: FAILED with %0d errors", name, errs);
		end
	endtask

	task automatic wait_request(output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < REQ_WAIT_CYCLES; n++) begin
			if (sd_rd_o || sd_wr_o) begin
				seen = 1'b1;
				break;
			end
			next_cycle();
		end
	endtask

	task automatic expect_quiet(input int cycles, input string what);
		int n;
		bit stray;
		stray = 1'b0;
		for (n = 0; n < cycles; n++) begin
			next_cycle();
			if (sd_rd_o || sd_wr_o) begin
				stray = 1'b1;
			end
		end
		if (stray) begin
			$display("Unexpected sector request after %s", what);
			err_cnt++;
		end
	endtask

	// ============================================================
	// Host SD model
	// ============================================================

	// Host answers a read request by writing the sector into the buffer
	task automatic serve_load_sector(input int sec);
		bit seen;
		int k;
		wait_request(seen);
		if (!seen) begin
			$display("Load: no request arrived for sector %0d", sec);
			err_cnt++;
			return;
		end
		if (!(sd_rd_o === 1'b1 && sd_wr_o === 1'b0)) begin
			$display("Load: request for sector %0d is not a read", sec);
			err_cnt++;
		end
		check_lba(sd_lba_o, sms_pkg::lba_t'(sec), sec);
		repeat (HOST_DELAY) next_cycle();
		sd_ack_i     = 1'b1;
		sd_buff_wr_i = 1'b1;
		for (k = 0; k < SECTOR_BYTES; k++) begin
			sd_buff_addr_i = sms_pkg::byte_addr_t'(k);
			sd_buff_dout_i = fill_byte(sec, k);
			next_cycle();
		end
		if (sd_rd_o) begin
			$display("Load: read request still high during sector %0d", sec);
			err_cnt++;
		end
		sd_buff_wr_i = 1'b0;
		sd_ack_i     = 1'b0;
	endtask

	// Host answers a write request by reading the buffer, one cycle latency
	task automatic serve_save_sector(input int sec);
		bit seen;
		int k;
		wait_request(seen);
		if (!seen) begin
			$display("Save: no request arrived for sector %0d", sec);
			err_cnt++;
			return;
		end
		if (!(sd_wr_o === 1'b1 && sd_rd_o === 1'b0)) begin
			$display("Save: request for sector %0d is not a write", sec);
			err_cnt++;
		end
		check_lba(sd_lba_o, sms_pkg::lba_t'(sec), sec);
		repeat (HOST_DELAY) next_cycle();
		sd_ack_i       = 1'b1;
		sd_buff_addr_i = '0;
		for (k = 1; k <= SECTOR_BYTES; k++) begin
			next_cycle();
			check_byte(sd_buff_din_o, save_img[sec * SECTOR_BYTES + k - 1],
				"host save read at byte", sec * SECTOR_BYTES + k - 1);
			if (k < SECTOR_BYTES) begin
				sd_buff_addr_i = sms_pkg::byte_addr_t'(k);
			end
		end
		sd_ack_i = 1'b0;
	endtask

	// ============================================================
	// Tests
	// ============================================================

	task automatic load_image();
		int errs_before;
		int sec;
		int k;
		int a;
		int pulses;
		int pulse_at;
		bit stray;
		errs_before   = err_cnt;
		img_size_i    = sms_pkg::lba_t'(RAM_BYTES);
		img_mounted_i = 1'b1;
		next_cycle();
		img_mounted_i = 1'b0;
		for (sec = 0; sec < SECTORS; sec++) begin
			serve_load_sector(sec);
		end
		// Core reset expected two cycles after the last ack fall
		pulses   = 0;
		pulse_at = 0;
		stray    = 1'b0;
		for (k = 1; k <= 8; k++) begin
			next_cycle();
			if (core_reset_o) begin
				pulses++;
				pulse_at = k;
			end
			if (sd_rd_o || sd_wr_o) begin
				stray = 1'b1;
			end
		end
		if (pulses != 1 || pulse_at != 2) begin
			$display("Load: core reset high %0d cycles, last at cycle %0d, expected one at 2",
				pulses, pulse_at);
			err_cnt++;
		end
		if (stray) begin
			$display("Load: a request followed the last sector");
			err_cnt++;
		end
		cart_addr_i = '0;
		for (a = 1; a <= RAM_BYTES; a++) begin
			next_cycle();
			check_byte(cart_rdata_o, fill_byte((a - 1) / SECTOR_BYTES, (a - 1) % SECTOR_BYTES),
				"cart read at byte", a - 1);
			if (a < RAM_BYTES) begin
				cart_addr_i = sms_pkg::nvram_addr_t'(a);
			end
		end
		report_result("load", errs_before);
	endtask

	task automatic save_image();
		int errs_before;
		int a;
		int sec;
		errs_before = err_cnt;
		cart_we_i   = 1'b1;
		for (a = 0; a < RAM_BYTES; a++) begin
			cart_addr_i  = sms_pkg::nvram_addr_t'(a);
			save_img[a]  = sms_pkg::data_t'($random(rand_seed));
			cart_wdata_i = save_img[a];
			next_cycle();
		end
		cart_we_i  = 1'b0;
		save_req_i = 1'b1;
		next_cycle();
		save_req_i = 1'b0;
		for (sec = 0; sec < SECTORS; sec++) begin
			serve_save_sector(sec);
		end
		expect_quiet(8, "the last saved sector");
		report_result("save", errs_before);
	endtask

	task automatic enable_rules();
		int errs_before;
		errs_before   = err_cnt;
		img_size_i    = '0;
		img_mounted_i = 1'b1;
		next_cycle();
		img_mounted_i = 1'b0;
		expect_quiet(10, "mounting an empty image");
		download_i = 1'b1;
		next_cycle();
		download_i = 1'b0;
		repeat (4) next_cycle();
		save_req_i = 1'b1;
		next_cycle();
		save_req_i = 1'b0;
		expect_quiet(10, "a save request following a download");
		report_result("enable rules", errs_before);
	endtask

	task automatic run_frame(input int f);
		int base;
		int i;
		int latency;
		int n;
		base  = SEED_WORDS + f * FRAME_WORDS;
		psg_i = stim_mem[base + 2 * SLOTS][15:0];
		for (i = 0; i < SLOTS; i++) begin
			opll_mo_i      = stim_mem[base + i][9:0];
			opll_ro_i      = stim_mem[base + SLOTS + i][9:0];
			opll_dac_clk_i = 1'b1;
			repeat (2) next_cycle();
			opll_dac_clk_i = 1'b0;
			if (i < SLOTS - 1) begin
				repeat (2) next_cycle();
			end
		end
		latency = -1;
		for (n = 1; n <= 8; n++) begin
			next_cycle();
			if (mix_valid_o) begin
				latency = n;
				break;
			end
		end
		if (latency < 0) begin
			$display("Audio: no mix_valid_o pulse after frame %0d", f);
			err_cnt++;
		end else begin
			if (latency != 2) begin
				$display("Audio: mix_valid_o came %0d cycles after frame %0d ended, expected 2",
					latency, f);
				err_cnt++;
			end
			check_mix(mix_o, stim_mem[base + 2 * SLOTS + 1][16:0], f);
		end
	endtask

	task automatic check_pulses(input int pulses_before, input int frames);
		repeat (2) next_cycle();
		if (valid_pulses - pulses_before != frames) begin
			$display("Audio: %0d mix_valid_o pulses for %0d frames",
				valid_pulses - pulses_before, frames);
			err_cnt++;
		end
	endtask

	task automatic audio_mix();
		int errs_before;
		int pulses_before;
		int f;
		errs_before   = err_cnt;
		pulses_before = valid_pulses;
		for (f = 0; f < FRAMES; f++) begin
			run_frame(f);
		end
		check_pulses(pulses_before, FRAMES);
		report_result("audio mix", errs_before);
	endtask

	// Small frames after the large ones show any leftover sum
	task automatic accumulator_clearing();
		int errs_before;
		int pulses_before;
		errs_before   = err_cnt;
		pulses_before = valid_pulses;
		run_frame(0);
		run_frame(1);
		check_pulses(pulses_before, 2);
		report_result("accumulator clearing", errs_before);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		reset_i        = 1'b1;
		img_mounted_i  = 1'b0;
		img_size_i     = '0;
		save_req_i     = 1'b0;
		download_i     = 1'b0;
		user_reset_i   = 1'b0;
		sd_ack_i       = 1'b0;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i   = 1'b0;
		cart_addr_i    = '0;
		cart_we_i      = 1'b0;
		cart_wdata_i   = '0;
		opll_dac_clk_i = 1'b0;
		opll_mo_i      = '0;
		opll_ro_i      = '0;
		psg_i          = '0;
		rand_seed      = 32'hd3083cfc;
		$readmemh(STIM_FILE, stim_mem);

		repeat (RESET_CYCLES) @(posedge clk_sys);
		#(DRIVE_DELAY);
		reset_i = 1'b0;
		next_cycle();

		load_image();
		save_image();
		enable_rules();
		audio_mix();
		accumulator_clearing();

		$display("Summary: %0d tests, %0d with errors, %0d errors in total",
			test_cnt, bad_test_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/sms_pkg.sv
source/host_buffer_if.sv
source/backup_sequencer.sv
source/nvram_buffer.sv
source/audio_mixer.sv
source/sms_host_bridge.sv
sim/sms_host_bridge_assert.sv
sim/tb_sms_host_bridge.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_sms_host_bridge
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build and run, a crashed run counts as a failure in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Test failed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/sms_stimulus.txt ====
// Words 0 to 15: fill seed of sectors 0 to 15
// Then four audio frames: 18 mo slots, 18 ro slots, psg, expected mix (two's complement hex)
3C A5 5A C3 0F F0 96 69
12 34 56 78 9A BC DE E1
// Frame 0, all positive
010 010 010 010 010 010 010 010 010
010 010 010 010 010 010 010 010 010
008 008 008 008 008 008 008 008 008
008 008 008 008 008 008 008 008 008
0100 002B0
// Frame 1, all negative
3F0 3F0 3F0 3F0 3F0 3F0 3F0 3F0 3F0
3F0 3F0 3F0 3F0 3F0 3F0 3F0 3F0 3F0
3F8 3F8 3F8 3F8 3F8 3F8 3F8 3F8 3F8
3F8 3F8 3F8 3F8 3F8 3F8 3F8 3F8 3F8
FF00 1FD50
// Frame 2, ramp on mo and full scale ro
001 002 003 004 005 006 007 008 009
00A 00B 00C 00D 00E 00F 010 011 012
1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF
1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF
7FFF 0A498
// Frame 3, mixed signs near the limits
200 200 200 200 200 200 200 200 200
200 200 200 200 200 200 200 200 200
1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF
1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF
8000 17FEE
